//--- Bender.yml
package:
  name: pipeline_core

sources:
  - target: rtl
    files:
      - rtl/core_pkg.sv
      - rtl/fetch_unit.sv
      - rtl/fetch_buffer.sv
      - rtl/decode_stage.sv
      - rtl/execute_stage.sv
      - rtl/result_stage.sv
      - rtl/core_top.sv
  - target: bench
    files:
      - bench/tb_core_top.sv

//--- bench/tb_core_top.sv
`timescale 1ns/1ps

module tb_core_top import core_pkg::*; ();

logic            clk       = 1'b0;
logic            reset     = 1'b1;
logic            wb_cyc;
logic            wb_stb;
logic [XLEN-1:0] wb_adr;
logic [XLEN-1:0] wb_dat    = '0;
logic            wb_ack    = 1'b0;
logic            wb_err    = 1'b0;
retire_t         retire;

logic [XLEN-1:0] mem [64];              // Program memory, aliased on adr[7:2].
integer          seed      = 32'hb60c;
int              waits_now;
int              wait_left = 0;
logic            busy      = 1'b0;      // Slave is counting wait states.

logic [XLEN-1:0] ref_regs [NREGS];      // Architectural model state.
logic [XLEN-1:0] ref_pc;
logic            model_stuck = 1'b0;

core_top u_dut (
        .i_clk    (clk),
        .i_reset  (reset),
        .o_wb_cyc (wb_cyc),
        .o_wb_stb (wb_stb),
        .o_wb_adr (wb_adr),
        .i_wb_dat (wb_dat),
        .i_wb_ack (wb_ack),
        .i_wb_err (wb_err),
        .o_retire (retire)
);

always
begin
        #50 clk = ~clk;                 // 100 ns period.
end

initial
begin
        load_program();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
end

// Wishbone slave, 0 to 3 wait states per access.
always @(posedge clk)
begin
        wb_ack <= 1'b0;                 // One-cycle response.
        wb_err <= 1'b0;
        if (!reset && wb_stb && !wb_ack && !wb_err)
        begin
                waits_now = busy ? wait_left : ($unsigned($random(seed)) % 4);
                if (waits_now == 0)
                begin
                        busy   <= 1'b0;
                        wb_ack <= !is_fault(wb_adr);
                        wb_err <= is_fault(wb_adr);     // Instruction abort.
                        wb_dat <= mem[wb_adr[7:2]];
                end
                else
                begin
                        busy      <= 1'b1;
                        wait_left <= waits_now - 1;
                end
        end
end

// The cycle line must frame every strobe.
always @(negedge clk)
begin
        if (!reset && wb_stb === 1'b1 && wb_cyc !== 1'b1)
        begin
                $display("** Error: o_wb_cyc got %h, expected 1", wb_cyc);
                stop_on_error();
        end
end

// Faulting fetch addresses; 0x54 sits on a path a branch skips.
function automatic logic is_fault(input logic [XLEN-1:0] adr);
        return (adr == 32'h54) || (adr == 32'h64);
endfunction

function automatic logic [XLEN-1:0] dp_reg(input logic [3:0] op, input int rd,
                                           input int rn, input int rm);
        return {4'hE, 2'b00, 1'b0, op, 1'b0, 4'(rn), 4'(rd), 8'h00, 4'(rm)};
endfunction

function automatic logic [XLEN-1:0] dp_imm(input logic [3:0] op, input int rd,
                                           input int rn, input logic [7:0] imm);
        return {4'hE, 2'b00, 1'b1, op, 1'b0, 4'(rn), 4'(rd), 4'h0, imm};
endfunction

function automatic logic [XLEN-1:0] branch_to(input int src, input int dst);
        int off;

        off = (dst - src - 8) / 4;      // Word offset from PC+8.
        return {4'hE, 3'b101, 1'b0, off[23:0]};
endfunction

task automatic place(input int adr, input logic [XLEN-1:0] word);
        mem[adr / 4] = word;
endtask

task automatic load_program();
        int i;

        for (i = 0; i < 64; i++)
                mem[i] = 32'hE3A0_1000 | (i * 4);       // MOV R1, #own address.
        place('h00, dp_imm(OP_MOV, 1, 0, 8'h5A));
        place('h04, dp_imm(OP_MOV, 2, 0, 8'h0F));
        place('h08, branch_to('h08, 'h10));             // Hop over the vector.
        place('h0C, branch_to('h0C, 'hA0));             // Abort vector.
        place('h10, dp_reg(OP_AND, 3, 1, 2));
        place('h14, dp_imm(OP_AND, 4, 1, 8'h3C));
        place('h18, dp_reg(OP_EOR, 5, 1, 2));
        place('h1C, dp_imm(OP_EOR, 5, 5, 8'hFF));       // Depends on R5.
        place('h20, dp_reg(OP_SUB, 6, 1, 2));
        place('h24, dp_imm(OP_SUB, 6, 2, 8'h10));       // Goes negative.
        place('h28, dp_reg(OP_ADD, 7, 6, 1));
        place('h2C, dp_imm(OP_ADD, 7, 7, 8'h22));
        place('h30, dp_reg(OP_ORR, 3, 3, 4));
        place('h34, dp_imm(OP_ORR, 4, 2, 8'hC0));
        place('h38, dp_reg(OP_MOV, 10, 0, 7));
        place('h3C, dp_imm(OP_MOV, 11, 0, 8'h99));
        place('h40, dp_imm(OP_ADD, 12, 15, 8'h00));     // R15 as Rn.
        place('h44, dp_reg(OP_MOV, 13, 0, 15));         // R15 as Rm.
        place('h48, dp_reg(OP_SUB, 12, 12, 13));
        place('h4C, dp_imm(OP_MOV, 15, 0, 8'h40));      // Dropped write.
        place('h50, branch_to('h50, 'h60));
        place('h54, dp_imm(OP_MOV, 0, 0, 8'h11));       // Shadow of the branch.
        place('h58, dp_imm(OP_MOV, 0, 0, 8'h22));
        place('h5C, dp_imm(OP_MOV, 0, 0, 8'h33));
        place('h60, dp_imm(OP_ADD, 0, 1, 8'h01));
        place('h64, dp_imm(OP_MOV, 14, 0, 8'hAB));      // Faults, R14 stays 0.
        place('h68, dp_reg(OP_EOR, 9, 8, 1));
        place('h6C, dp_reg(OP_ADD, 14, 14, 9));
        place('h70, branch_to('h70, 'h70));             // End loop.
        place('hA0, dp_imm(OP_MOV, 8, 0, 8'h77));       // Abort handler.
        place('hA4, dp_reg(OP_ADD, 8, 8, 0));
        place('hA8, branch_to('hA8, 'h68));             // Resume after the fault.
endtask

// Steps the model to its next retire event.
function automatic retire_t next_expected(output logic done);
        retire_t         ev;
        instr_t          w;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] target;
        logic            known;
        int              steps;

        ev   = '0;
        done = 1'b0;
        for (steps = 0; steps < 64; steps++)
        begin
                w = mem[ref_pc[7:2]];
                if (is_fault(ref_pc))
                begin
                        ev.valid    = 1'b1;
                        ev.is_abort = 1'b1;
                        ev.pc       = ref_pc;
                        ref_pc      = ABORT_VECTOR;
                        return ev;
                end
                if (w.br.cls == 3'b101)
                begin
                        target = ref_pc + 32'd8 + {{6{w.br.offset[23]}}, w.br.offset, 2'b00};
                        if (target == ref_pc)
                        begin
                                done = 1'b1;            // Parked in the end loop.
                                return ev;
                        end
                        ref_pc = target;                // Branches retire nothing.
                        continue;
                end
                a = (w.dp.rn == 4'd15) ? ref_pc + 32'd8 : ref_regs[w.dp.rn];
                b = (w.dp.operand[3:0] == 4'd15) ? ref_pc + 32'd8
                                                 : ref_regs[w.dp.operand[3:0]];
                if (w.dp.imm_flag)
                        b = {24'h0, w.dp.operand[7:0]};
                known = 1'b1;
                case (w.dp.opcode)
                4'd0:    res = a & b;
                4'd1:    res = a ^ b;
                4'd2:    res = a - b;
                4'd4:    res = a + b;
                4'd12:   res = a | b;
                4'd13:   res = b;
                default:
                begin
                        res   = '0;
                        known = 1'b0;
                end
                endcase
                if (known && w.dp.rd != 4'd15)
                begin
                        ref_regs[w.dp.rd] = res;
                        ev.valid = 1'b1;
                        ev.rd    = w.dp.rd;
                        ev.value = res;
                        ev.pc    = ref_pc;
                        ref_pc   = ref_pc + 32'd4;
                        return ev;
                end
                ref_pc = ref_pc + 32'd4;                // No write, no event.
        end
        model_stuck = 1'b1;
        done        = 1'b1;
        return ev;
endfunction

task automatic stop_on_error();
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopped at the first error.");
endtask

task automatic check_wb_adr(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        if (got !== exp)
        begin
                $display("** Error: o_wb_adr got %h, expected %h", got, exp);
                stop_on_error();
        end
endtask

task automatic check_retire_write(input retire_t got, input retire_t exp);
        if (got.is_abort !== 1'b0 || got.rd !== exp.rd || got.value !== exp.value ||
            got.pc !== exp.pc)
        begin
                $display("** Error: o_retire got is_abort=%h rd=%h value=%h pc=%h",
                         got.is_abort, got.rd, got.value, got.pc);
                $display("** Error: o_retire expected is_abort=0 rd=%h value=%h pc=%h",
                         exp.rd, exp.value, exp.pc);
                stop_on_error();
        end
endtask

task automatic check_retire_abort(input retire_t got, input retire_t exp);
        if (got.is_abort !== 1'b1 || got.pc !== exp.pc)
        begin
                $display("** Error: o_retire got is_abort=%h pc=%h, expected is_abort=1 pc=%h",
                         got.is_abort, got.pc, exp.pc);
                stop_on_error();
        end
endtask

task automatic wait_retire();
        int cycles;

        cycles = 0;
        do
        begin
                @(negedge clk);
                cycles++;
        end
        while (retire.valid !== 1'b1 && cycles < 200);
        if (retire.valid !== 1'b1)
        begin
                $display("Timed out waiting for a retire event.");
                stop_on_error();
        end
endtask

initial
begin : run_checks
        retire_t exp;
        logic    done;
        int      cycles;
        int      events;
        int      i;

        for (i = 0; i < NREGS; i++)
                ref_regs[i] = '0;
        ref_pc = RESET_PC;
        cycles = 0;
        while (reset && cycles < 20)
        begin
                @(negedge clk);
                cycles++;
                if (retire.valid !== 1'b0 || wb_cyc !== 1'b0)
                begin
                        $display("A retire event or bus cycle appeared during reset.");
                        stop_on_error();
                end
        end
        if (reset)
        begin
                $display("Timed out waiting for reset to be released.");
                stop_on_error();
        end
        cycles = 0;
        do
        begin
                @(negedge clk);
                cycles++;
        end
        while (wb_stb !== 1'b1 && cycles < 10);
        if (wb_stb !== 1'b1)
        begin
                $display("Timed out waiting for the first fetch request.");
                stop_on_error();
        end
        check_wb_adr(wb_adr, RESET_PC);
        events = 0;
        exp    = next_expected(done);
        while (!done)
        begin
                wait_retire();
                if (exp.is_abort)
                        check_retire_abort(retire, exp);
                else
                        check_retire_write(retire, exp);
                events++;
                exp = next_expected(done);
        end
        if (model_stuck)
        begin
                $display("The reference model never reached the end loop.");
                stop_on_error();
        end
        repeat (30)
        begin
                @(negedge clk);
                if (retire.valid !== 1'b0)      // Core should idle in the end loop.
                begin
                        $display("An extra retire event appeared after the program ended.");
                        stop_on_error();
                end
        end
        $display("Checked %0d retire events.", events);
        $display("TESTBENCH PASSED");
        $finish;
end

endmodule

//--- project.f
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/fetch_buffer.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/core_top.sv
bench/tb_core_top.sv

//--- rtl/core_pkg.sv
package core_pkg;

        localparam int XLEN  = 32;                      // Data and address width.
        localparam int NREGS = 16;                      // Register count.
        localparam int REGW  = $clog2(NREGS);           // Register index width.

        localparam logic [REGW-1:0] PC_REG        = REGW'(15);   // Reads as PC+8.
        localparam logic [XLEN-1:0] RESET_PC      = 32'h0000_0000;
        localparam logic [XLEN-1:0] ABORT_VECTOR  = 32'h0000_000C;
        localparam logic [XLEN-1:0] ABORT_PAYLOAD = 32'h0000_0000; // AND R0, R0, R0.

        // Supported data-processing opcodes.
        localparam logic [3:0] OP_AND = 4'd0;
        localparam logic [3:0] OP_EOR = 4'd1;
        localparam logic [3:0] OP_SUB = 4'd2;
        localparam logic [3:0] OP_ADD = 4'd4;
        localparam logic [3:0] OP_ORR = 4'd12;
        localparam logic [3:0] OP_MOV = 4'd13;

        localparam logic [2:0] BRANCH_CLASS = 3'b101;   // Bits 27..25 of a branch.

        // Fetch FSM encodings.
        localparam logic [1:0] FS_IDLE    = 2'd0;       // Strobes low.
        localparam logic [1:0] FS_REQ     = 2'd1;       // Cycle open, word wanted.
        localparam logic [1:0] FS_DISCARD = 2'd2;       // Cycle open, word dropped.

        typedef struct packed {
                logic [3:0]      cond;
                logic [1:0]      cls;           // 00 for data processing.
                logic            imm_flag;
                logic [3:0]      opcode;
                logic            set_flags;     // No flags, ignored.
                logic [REGW-1:0] rn;
                logic [REGW-1:0] rd;
                logic [11:0]     operand;       // Imm in [7:0] or Rm in [3:0].
        } dp_fmt_t;

        typedef struct packed {
                logic [3:0]  cond;
                logic [2:0]  cls;
                logic        link;              // No link register support.
                logic [23:0] offset;            // Signed word offset.
        } br_fmt_t;

        // One fetched word, read either way by decode.
        typedef union packed {
                dp_fmt_t dp;
                br_fmt_t br;
        } instr_t;

        typedef struct packed {
                logic            valid;
                logic            abort;
                instr_t          instruction;
                logic [XLEN-1:0] pc_plus_8;
        } fetch_t;

        typedef struct packed {
                logic            valid;
                logic            abort;
                logic            is_branch;
                logic [3:0]      opcode;
                logic            writes_rd;
                logic [REGW-1:0] rd;
                logic [REGW-1:0] rn_index;
                logic [REGW-1:0] rm_index;
                logic            use_imm;
                logic [XLEN-1:0] imm;
                logic [XLEN-1:0] rn_value;
                logic [XLEN-1:0] rm_value;
                logic [XLEN-1:0] branch_target;
                logic [XLEN-1:0] pc_plus_8;
        } decoded_t;

        typedef struct packed {
                logic            valid;
                logic            abort;
                logic            writes_rd;
                logic [REGW-1:0] rd;
                logic [XLEN-1:0] result;
                logic [XLEN-1:0] pc;
        } exec_t;

        typedef struct packed {
                logic            valid;
                logic            is_abort;
                logic [REGW-1:0] rd;
                logic [XLEN-1:0] value;
                logic [XLEN-1:0] pc;
        } retire_t;

        typedef struct packed {
                logic            flag;
                logic [XLEN-1:0] target;
        } clear_t;

endpackage

//--- rtl/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        output logic            o_wb_cyc,
        output logic            o_wb_stb,
        output logic [XLEN-1:0] o_wb_adr,
        input  logic [XLEN-1:0] i_wb_dat,
        input  logic            i_wb_ack,
        input  logic            i_wb_err,
        output retire_t         o_retire
);

logic [XLEN-1:0] fu_instruction;
logic            fu_valid;
logic            fu_abort;
logic [XLEN-1:0] fu_pc;
fetch_t          fetch;
decoded_t        decoded;
exec_t           exec;
clear_t          clear_from_execute;
clear_t          clear_from_result;
logic [REGW-1:0] rn_index;
logic [REGW-1:0] rm_index;
logic [XLEN-1:0] rn_value;
logic [XLEN-1:0] rm_value;

fetch_unit u_fetch_unit (
        .i_clk                (i_clk),
        .i_reset              (i_reset),
        .i_clear_from_result  (clear_from_result),
        .i_clear_from_execute (clear_from_execute),
        .o_wb_cyc             (o_wb_cyc),
        .o_wb_stb             (o_wb_stb),
        .o_wb_adr             (o_wb_adr),
        .i_wb_dat             (i_wb_dat),
        .i_wb_ack             (i_wb_ack),
        .i_wb_err             (i_wb_err),
        .o_instruction        (fu_instruction),
        .o_valid              (fu_valid),
        .o_instr_abort        (fu_abort),
        .o_pc                 (fu_pc)
);

fetch_buffer u_fetch_buffer (
        .i_clk                (i_clk),
        .i_reset              (i_reset),
        .i_clear_from_result  (clear_from_result),
        .i_clear_from_execute (clear_from_execute),
        .i_instruction        (fu_instruction),
        .i_valid              (fu_valid),
        .i_instr_abort        (fu_abort),
        .i_pc                 (fu_pc),
        .o_fetch              (fetch)
);

decode_stage u_decode_stage (
        .i_clk                (i_clk),
        .i_reset              (i_reset),
        .i_clear_from_result  (clear_from_result),
        .i_clear_from_execute (clear_from_execute),
        .i_fetch              (fetch),
        .o_rn_index           (rn_index),
        .o_rm_index           (rm_index),
        .i_rn_value           (rn_value),
        .i_rm_value           (rm_value),
        .o_decoded            (decoded)
);

execute_stage u_execute_stage (
        .i_clk                (i_clk),
        .i_reset              (i_reset),
        .i_clear_from_result  (clear_from_result),
        .i_decoded            (decoded),
        .o_exec               (exec),
        .o_clear              (clear_from_execute)
);

result_stage u_result_stage (
        .i_clk                (i_clk),
        .i_reset              (i_reset),
        .i_exec               (exec),
        .i_rn_index           (rn_index),
        .i_rm_index           (rm_index),
        .o_rn_value           (rn_value),
        .o_rm_value           (rm_value),
        .o_clear              (clear_from_result),
        .o_retire             (o_retire)
);

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import core_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  clear_t          i_clear_from_result,
        input  clear_t          i_clear_from_execute,
        input  fetch_t          i_fetch,
        output logic [REGW-1:0] o_rn_index,     // To register file.
        output logic [REGW-1:0] o_rm_index,
        input  logic [XLEN-1:0] i_rn_value,     // Write-through values.
        input  logic [XLEN-1:0] i_rm_value,
        output decoded_t        o_decoded
);

instr_t          instr;
decoded_t        dec_next;
logic            is_branch;
logic            known_op;
logic [XLEN-1:0] br_offset;

assign instr      = i_fetch.instruction;
assign is_branch  = (instr.br.cls == BRANCH_CLASS);
assign o_rn_index = instr.dp.rn;
assign o_rm_index = instr.dp.operand[REGW-1:0];
assign br_offset  = {{(XLEN-26){instr.br.offset[23]}}, instr.br.offset, 2'b00};

always_comb
begin
        case (instr.dp.opcode)
        OP_AND, OP_EOR, OP_SUB, OP_ADD, OP_ORR, OP_MOV:
                known_op = 1'b1;
        default:
                known_op = 1'b0;                        // Retires nothing.
        endcase
end

always_comb
begin
        dec_next.valid         = i_fetch.valid;
        dec_next.abort         = i_fetch.abort;
        dec_next.is_branch     = is_branch && !i_fetch.abort;
        dec_next.opcode        = instr.dp.opcode;
        // R15 writes are dropped here.
        dec_next.writes_rd     = known_op && !is_branch && !i_fetch.abort &&
                                 (instr.dp.rd != PC_REG);
        dec_next.rd            = instr.dp.rd;
        dec_next.rn_index      = o_rn_index;
        dec_next.rm_index      = o_rm_index;
        dec_next.use_imm       = instr.dp.imm_flag;
        dec_next.imm           = {{(XLEN-8){1'b0}}, instr.dp.operand[7:0]}; // No rotate.
        dec_next.rn_value      = (o_rn_index == PC_REG) ? i_fetch.pc_plus_8 : i_rn_value;
        dec_next.rm_value      = (o_rm_index == PC_REG) ? i_fetch.pc_plus_8 : i_rm_value;
        dec_next.branch_target = i_fetch.pc_plus_8 + br_offset;
        dec_next.pc_plus_8     = i_fetch.pc_plus_8;
end

always_ff @(posedge i_clk)
begin
        o_decoded <= dec_next;
        if (i_reset || i_clear_from_result.flag || i_clear_from_execute.flag)
        begin
                o_decoded.valid <= 1'b0;                // Squash, payload is don't care.
                o_decoded.abort <= 1'b0;
        end
end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import core_pkg::*;
(
        input  logic     i_clk,
        input  logic     i_reset,
        input  clear_t   i_clear_from_result,
        input  decoded_t i_decoded,
        output exec_t    o_exec,
        output clear_t   o_clear                // Taken branch, one cycle.
);

logic [XLEN-1:0] rn_fwd;
logic [XLEN-1:0] rm_fwd;
logic [XLEN-1:0] op2;
logic [XLEN-1:0] alu_out;
logic            fwd_ok;
logic            kill;

// Our own result is not yet in the register file.
assign fwd_ok = o_exec.valid && o_exec.writes_rd;
assign rn_fwd = (fwd_ok && o_exec.rd == i_decoded.rn_index) ? o_exec.result
                                                             : i_decoded.rn_value;
assign rm_fwd = (fwd_ok && o_exec.rd == i_decoded.rm_index) ? o_exec.result
                                                             : i_decoded.rm_value;
assign op2    = i_decoded.use_imm ? i_decoded.imm : rm_fwd;

// Input is younger than a branch or abort that is leaving now.
assign kill = i_clear_from_result.flag || o_clear.flag;

always_comb
begin
        case (i_decoded.opcode)
        OP_AND:  alu_out = rn_fwd & op2;
        OP_EOR:  alu_out = rn_fwd ^ op2;
        OP_SUB:  alu_out = rn_fwd - op2;
        OP_ADD:  alu_out = rn_fwd + op2;
        OP_ORR:  alu_out = rn_fwd | op2;
        OP_MOV:  alu_out = op2;
        default: alu_out = '0;                          // Not written back.
        endcase
end

always_ff @(posedge i_clk)
begin
        o_exec.abort     <= i_decoded.abort;
        o_exec.writes_rd <= i_decoded.writes_rd;
        o_exec.rd        <= i_decoded.rd;
        o_exec.result    <= alu_out;
        o_exec.pc        <= i_decoded.pc_plus_8 - 32'd8;
        o_clear.target   <= i_decoded.branch_target;
        if (i_reset)
        begin
                o_exec.valid <= 1'b0;
                o_clear.flag <= 1'b0;
        end
        else
        begin
                // Branches retire nothing, they only redirect.
                o_exec.valid <= i_decoded.valid && !i_decoded.is_branch && !kill;
                o_clear.flag <= i_decoded.valid && i_decoded.is_branch && !kill;
        end
end

// An aborted word is never treated as a branch.
a_no_clear_on_abort: assert property (@(posedge i_clk) disable iff (i_reset)
        i_decoded.valid && i_decoded.abort |=> !o_clear.flag);

endmodule

//--- rtl/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer import core_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  clear_t          i_clear_from_result,    // High priority.
        input  clear_t          i_clear_from_execute,   // Low priority.
        input  logic [XLEN-1:0] i_instruction,
        input  logic            i_valid,
        input  logic            i_instr_abort,
        input  logic [XLEN-1:0] i_pc,
        output fetch_t          o_fetch
);

logic            valid_ff;
logic            abort_ff;
logic [XLEN-1:0] instr_ff;
logic [XLEN-1:0] pc_buff;               // PC of the held word.

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                valid_ff <= 1'b0;
                abort_ff <= 1'b0;
                pc_buff  <= RESET_PC;
        end
        else if (i_clear_from_result.flag)
        begin
                valid_ff <= 1'b0;                       // Abort redirect empties us.
                abort_ff <= 1'b0;
        end
        else if (i_clear_from_execute.flag)
        begin
                valid_ff <= 1'b0;                       // Taken branch empties us.
                abort_ff <= 1'b0;
        end
        else
        begin
                // An abort carries no word, so force valid to keep it in order.
                valid_ff <= i_valid || i_instr_abort;
                abort_ff <= i_instr_abort;
                if (i_valid || i_instr_abort)
                        pc_buff <= i_pc;                // Advance only on capture.
        end
end

// Harmless payload in place of a faulted word.
always_ff @(posedge i_clk)
begin
        instr_ff <= i_instr_abort ? ABORT_PAYLOAD : i_instruction;
end

assign o_fetch.valid       = valid_ff;
assign o_fetch.abort       = abort_ff;
assign o_fetch.instruction = instr_ff;
assign o_fetch.pc_plus_8   = pc_buff + 32'd8;   // Pipelined PC view.

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import core_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  clear_t          i_clear_from_result,    // High priority.
        input  clear_t          i_clear_from_execute,   // Low priority.
        output logic            o_wb_cyc,
        output logic            o_wb_stb,
        output logic [XLEN-1:0] o_wb_adr,
        input  logic [XLEN-1:0] i_wb_dat,
        input  logic            i_wb_ack,
        input  logic            i_wb_err,
        output logic [XLEN-1:0] o_instruction,
        output logic            o_valid,                // One-cycle pulse.
        output logic            o_instr_abort,
        output logic [XLEN-1:0] o_pc
);

logic [1:0]      state_ff;
logic [XLEN-1:0] pc_ff;                 // Address of current or next fetch.
logic [XLEN-1:0] target_ff;             // Redirect held during a discard.
logic            clr;
logic [XLEN-1:0] clr_target;
logic            bus_done;

assign clr        = i_clear_from_result.flag || i_clear_from_execute.flag;
assign clr_target = i_clear_from_result.flag ? i_clear_from_result.target
                                             : i_clear_from_execute.target;
assign bus_done   = i_wb_ack || i_wb_err;       // Either ends the cycle.

assign o_wb_cyc = (state_ff != FS_IDLE);
assign o_wb_stb = (state_ff != FS_IDLE);        // Classic, so stb follows cyc.
assign o_wb_adr = pc_ff;

// Word goes straight to the fetch buffer; a clear kills it in flight.
assign o_instruction = i_wb_dat;
assign o_valid       = (state_ff == FS_REQ) && i_wb_ack && !clr;
assign o_instr_abort = (state_ff == FS_REQ) && i_wb_err && !i_wb_ack && !clr;
assign o_pc          = pc_ff;

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_ff <= FS_IDLE;
                pc_ff    <= RESET_PC;
        end
        else
        begin
                case (state_ff)
                FS_IDLE:
                begin
                        state_ff <= FS_REQ;                     // One idle cycle minimum.
                        if (clr)
                                pc_ff <= clr_target;
                end
                FS_REQ:
                begin
                        if (bus_done)
                        begin
                                state_ff <= FS_IDLE;
                                pc_ff    <= clr ? clr_target : pc_ff + 32'd4;
                        end
                        else if (clr)
                        begin
                                state_ff  <= FS_DISCARD;        // Must finish the cycle.
                                target_ff <= clr_target;
                        end
                end
                FS_DISCARD:
                begin
                        if (clr)
                                target_ff <= clr_target;        // Newest clear wins.
                        if (bus_done)
                        begin
                                state_ff <= FS_IDLE;
                                pc_ff    <= clr ? clr_target : target_ff;
                        end
                end
                default:
                        state_ff <= FS_IDLE;
                endcase
        end
end

// Wishbone classic rules as seen by the slave.
a_gap_after_ack: assert property (@(posedge i_clk) disable iff (i_reset)
        o_wb_stb && (i_wb_ack || i_wb_err) |=> !o_wb_stb);

a_adr_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        o_wb_stb && !(i_wb_ack || i_wb_err) |=> o_wb_stb && $stable(o_wb_adr));

endmodule

//--- rtl/result_stage.sv
`timescale 1ns/1ps

module result_stage import core_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  exec_t           i_exec,
        input  logic [REGW-1:0] i_rn_index,
        input  logic [REGW-1:0] i_rm_index,
        output logic [XLEN-1:0] o_rn_value,
        output logic [XLEN-1:0] o_rm_value,
        output clear_t          o_clear,        // Abort redirect, top priority.
        output retire_t         o_retire
);

logic [XLEN-1:0] regs [NREGS];
logic            we;

assign we = i_exec.valid && i_exec.writes_rd && !i_exec.abort;

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int i = 0; i < NREGS; i++)
                        regs[i] <= '0;
        end
        else if (we)
        begin
                regs[i_exec.rd] <= i_exec.result;
        end
end

// Same-cycle write passes straight to decode.
assign o_rn_value = (we && i_exec.rd == i_rn_index) ? i_exec.result : regs[i_rn_index];
assign o_rm_value = (we && i_exec.rd == i_rm_index) ? i_exec.result : regs[i_rm_index];

assign o_clear.flag   = i_exec.valid && i_exec.abort;
assign o_clear.target = ABORT_VECTOR;

// Aborts and register writes retire; dropped writes do not.
assign o_retire.valid    = i_exec.valid && (i_exec.writes_rd || i_exec.abort);
assign o_retire.is_abort = i_exec.abort;
assign o_retire.rd       = i_exec.rd;
assign o_retire.value    = i_exec.result;
assign o_retire.pc       = i_exec.pc;

// Decode must already have dropped writes to R15.
a_no_pc_write: assert property (@(posedge i_clk) disable iff (i_reset)
        we |-> (i_exec.rd != PC_REG));

endmodule
